//--- vlog.f
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_fetch.sv
source/rv_core.sv
sim/rv_core_assert.sv
sim/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= rv_core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
	import rv_pkg::*;

	typedef struct packed {
		word_t instr;
		word_t pc;   // Expected imem_addr
		logic  st;   // Store expected in this cycle
		word_t addr;
		word_t data;
		strb_t strb;
	} row_t;

	logic  clk;
	logic  reset;
	word_t imem_addr, imem_data;
	word_t dmem_addr, dmem_wdata, dmem_rdata;
	strb_t dmem_strb;
	logic  dmem_we;

	word_t rom [0:127];
	word_t ram [0:127] = '{default: '0};
	row_t  rows [$];
	word_t pc_cursor;     // PC of the next row while the table is built
	word_t slot;          // Next scratch word for result dumps
	int    cycles = 0;
	int    cycle_limit = 0;

	rv_core rv_core_inst (
		.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_strb(dmem_strb),
		.dmem_we(dmem_we), .dmem_rdata(dmem_rdata)
	);

	// Both memories answer in the same cycle
	assign imem_data  = rom[imem_addr[8:2]];
	assign dmem_rdata = ram[dmem_addr[8:2]];

	always @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (dmem_we && dmem_strb[b]) begin
				ram[dmem_addr[8:2]][8*b +: 8] <= dmem_wdata[8*b +: 8]; // Enabled lanes only
			end
		end
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: program did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	// RV32I instruction formats
	function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction
	function automatic word_t enc_i(int imm, int rs1, int f3, int rd, int op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction
	function automatic word_t enc_s(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction
	function automatic word_t enc_b(int imm, int rs1, int rs2, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction
	function automatic word_t enc_j(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic add(word_t instr, int step, logic st, word_t addr, word_t data, strb_t strb);
		rows.push_back('{instr, pc_cursor, st, addr, data, strb});
		pc_cursor = pc_cursor + word_t'(step); // Next PC by the ISA rule
	endtask

	// SW of a register to the next scratch word
	task automatic dump(int rd, word_t exp_val);
		add(enc_s(int'(slot), rd, 0, 2), 4, 1'b1, slot, exp_val, 4'b1111);
		slot = slot + 32'd4;
	endtask

	task automatic alu(word_t instr, int rd, word_t exp_val);
		add(instr, 4, 1'b0, '0, '0, '0);
		dump(rd, exp_val);
	endtask

	task automatic branch(int f3, int rs1, int rs2, int off, logic taken);
		add(enc_b(off, rs1, rs2, f3), taken ? off : 4, 1'b0, '0, '0, '0);
	endtask

	task automatic build_table();
		word_t jal_base;
		add(enc_s('h80, 0, 0, 2), 4, 1'b1, 32'h80, '0, 4'b1111); // At PC 0, idle in reset
		alu(enc_i(-7, 0, 0, 1, 'h13), 1, 32'hFFFFFFF9);
		alu(enc_i(5, 0, 0, 2, 'h13), 2, 32'h5);
		alu(enc_i('h23, 0, 0, 5, 'h13), 5, 32'h23);    // Shift by 35 acts as 3
		alu(enc_i(5, 0, 0, 0, 'h13), 0, 32'h0);        // x0 stays zero
		alu(enc_r(0, 2, 1, 0, 3), 3, 32'hFFFFFFFE);    // ADD
		alu(enc_r('h20, 1, 2, 0, 3), 3, 32'hC);        // SUB
		alu(enc_r(0, 2, 2, 1, 3), 3, 32'hA0);          // SLL
		alu(enc_r(0, 5, 2, 1, 3), 3, 32'h28);
		alu(enc_r(0, 2, 1, 2, 3), 3, 32'h1);           // SLT
		alu(enc_r(0, 2, 1, 3, 3), 3, 32'h0);           // SLTU
		alu(enc_r(0, 2, 1, 4, 3), 3, 32'hFFFFFFFC);    // XOR
		alu(enc_r(0, 2, 1, 5, 3), 3, 32'h07FFFFFF);    // SRL
		alu(enc_r('h20, 2, 1, 5, 3), 3, 32'hFFFFFFFF); // SRA
		alu(enc_r(0, 2, 1, 6, 3), 3, 32'hFFFFFFFD);    // OR
		alu(enc_r(0, 2, 1, 7, 3), 3, 32'h1);           // AND
		alu(enc_i(-6, 1, 2, 3, 'h13), 3, 32'h1);       // SLTI
		alu(enc_i(-1, 2, 3, 3, 'h13), 3, 32'h1);       // SLTIU
		alu(enc_i(-1, 2, 4, 3, 'h13), 3, 32'hFFFFFFFA);
		alu(enc_i('h30, 2, 6, 3, 'h13), 3, 32'h35);
		alu(enc_i('hF0, 1, 7, 3, 'h13), 3, 32'hF0);
		alu(enc_i(30, 2, 1, 3, 'h13), 3, 32'h40000000);
		alu(enc_i(28, 1, 5, 3, 'h13), 3, 32'hF);
		alu(enc_i('h401, 1, 5, 3, 'h13), 3, 32'hFFFFFFFC); // SRAI by 1
		alu(enc_i(-1883, 0, 0, 6, 'h13), 6, 32'hFFFFF8A5);
		add(enc_s('h41, 6, 0, 0), 4, 1'b1, 32'h41, 32'hA5A5A5A5, 4'b0010);
		add(enc_s('h43, 1, 0, 0), 4, 1'b1, 32'h43, 32'hF9F9F9F9, 4'b1000);
		add(enc_s('h46, 6, 0, 1), 4, 1'b1, 32'h46, 32'hF8A5F8A5, 4'b1100);
		add(enc_s('h4C, 6, 0, 1), 4, 1'b1, 32'h4C, 32'hF8A5F8A5, 4'b0011);
		add(enc_s('h48, 6, 0, 2), 4, 1'b1, 32'h48, 32'hFFFFF8A5, 4'b1111);
		alu(enc_i('h41, 0, 0, 7, 'h03), 7, 32'hFFFFFFA5); // LB
		alu(enc_i('h43, 0, 4, 7, 'h03), 7, 32'hF9);       // LBU
		alu(enc_i('h46, 0, 1, 7, 'h03), 7, 32'hFFFFF8A5); // LH
		alu(enc_i('h4C, 0, 5, 7, 'h03), 7, 32'hF8A5);     // LHU
		alu(enc_i('h40, 0, 2, 7, 'h03), 7, 32'hF900A500); // LW, two SB lanes
		branch(0, 2, 2, 8, 1'b1);
		branch(0, 1, 2, 8, 1'b0);
		branch(1, 1, 2, 12, 1'b1);
		branch(1, 2, 2, 8, 1'b0);
		branch(4, 1, 2, 8, 1'b1);  // -7 < 5 signed
		branch(4, 2, 1, 8, 1'b0);
		branch(5, 2, 1, 16, 1'b1);
		branch(5, 1, 2, 8, 1'b0);
		branch(6, 2, 1, 8, 1'b1);  // 5 below 0xFFFFFFF9 unsigned
		branch(6, 1, 2, 8, 1'b0);
		branch(7, 1, 2, 8, 1'b1);
		branch(7, 2, 1, 8, 1'b0);
		jal_base = pc_cursor;
		add(enc_j(12, 8), 12, 1'b0, '0, '0, '0);
		add(enc_j(-8, 0), -8, 1'b0, '0, '0, '0);  // Back into the gap
		add(enc_j(12, 9), 12, 1'b0, '0, '0, '0);
		dump(8, jal_base + 32'd4);
		dump(9, jal_base + 32'd8);
	endtask

	task automatic check(string what, word_t got, word_t exp_val);
		if (got !== exp_val) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp_val);
			$display("=== FAIL ===");
			$fatal(1, "mismatch");
		end
	endtask

	initial begin
		reset = 1'b1;
		pc_cursor = '0;
		slot = 32'h100;
		for (int i = 0; i < 128; i++) begin
			rom[i] = '0; // Zero word decodes as a no-op
		end
		build_table();
		foreach (rows[i]) begin
			rom[rows[i].pc[8:2]] = rows[i].instr;
		end
		cycle_limit = rows.size() + 5 + 20;
		repeat (2) @(posedge clk);
		#2;
		check("dmem_we in reset", {31'b0, dmem_we}, '0);
		check("imem_addr in reset", imem_addr, '0);
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		#1;
		foreach (rows[i]) begin
			check($sformatf("row %0d imem_addr", i), imem_addr, rows[i].pc);
			check($sformatf("row %0d dmem_we", i), {31'b0, dmem_we}, {31'b0, rows[i].st});
			if (rows[i].st) begin
				check($sformatf("row %0d dmem_addr", i), dmem_addr, rows[i].addr);
				check($sformatf("row %0d dmem_wdata", i), dmem_wdata, rows[i].data);
				check($sformatf("row %0d dmem_strb", i), {28'b0, dmem_strb},
					{28'b0, rows[i].strb});
			end
			@(posedge clk);
			#2;
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- sim/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert (
	input logic          clk,
	input logic          reset,
	input rv_pkg::word_t imem_addr,
	input logic          dmem_we,
	input rv_pkg::strb_t dmem_strb
);

	// A write must enable at least one lane
	strb_nonzero: assert property (@(posedge clk) dmem_we |-> (dmem_strb != '0))
		else $error("dmem_we high with an empty strobe");

	// PC only moves by words, checked once out of reset
	pc_aligned: assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
		else $error("imem_addr not word aligned");

	no_write_in_reset: assert property (@(posedge clk) reset |-> !dmem_we)
		else $error("dmem_we high during reset");

endmodule

bind rv_core rv_core_assert rv_core_assert_inst (.clk(clk), .reset(reset),
	.imem_addr(imem_addr), .dmem_we(dmem_we), .dmem_strb(dmem_strb));

//--- source/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic          clk,
	input  logic          reset,
	output rv_pkg::word_t imem_addr,
	input  rv_pkg::word_t imem_data,
	output rv_pkg::word_t dmem_addr,
	output rv_pkg::word_t dmem_wdata,
	output rv_pkg::strb_t dmem_strb,
	output logic          dmem_we,
	input  rv_pkg::word_t dmem_rdata
);
	import rv_pkg::*;

	reg_addr_t rs1, rs2, rd;
	word_t     imm;
	alu_op_t   alu_op;
	funct3_t   funct3;
	wb_sel_t   wb_sel;
	logic      sel_b, reg_wr, mem_rd, mem_wr, is_branch, is_jal;
	logic      br_taken;
	word_t     rs1_data, rs2_data;
	word_t     alu_b, alu_result;
	word_t     mem_addr; // Zero unless a load or store runs
	word_t     load_data, wb_data;
	word_t     pc, pc_plus4;

	assign imem_addr = pc;

	rv_decoder decoder_inst (
		.instr(imem_data), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.alu_op(alu_op), .funct3(funct3), .sel_b(sel_b), .reg_wr(reg_wr),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .is_branch(is_branch),
		.is_jal(is_jal), .wb_sel(wb_sel)
	);

	rv_regfile regfile_inst (
		.clk(clk), .reset(reset), .we(reg_wr), .rs1(rs1), .rs2(rs2),
		.rd(rd), .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	assign alu_b = sel_b ? imm : rs2_data; // Immediate or rs2

	rv_alu alu_inst (
		.a(rs1_data), .b(alu_b), .alu_op(alu_op), .funct3(funct3),
		.result(alu_result), .br_taken(br_taken)
	);

	// Data bus address stays quiet outside memory ops
	assign mem_addr = (mem_rd | mem_wr) ? alu_result : '0;

	rv_lsu lsu_inst (
		.addr(mem_addr), .store_data(rs2_data), .funct3(funct3),
		.mem_wr(mem_wr & ~reset), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_strb(dmem_strb), .dmem_we(dmem_we), .dmem_rdata(dmem_rdata),
		.load_data(load_data)
	);

	rv_fetch fetch_inst (
		.clk(clk), .reset(reset), .is_branch(is_branch), .br_taken(br_taken),
		.is_jal(is_jal), .imm(imm), .pc(pc), .pc_plus4(pc_plus4)
	);

	// Write-back source
	always_comb begin
		case (wb_sel)
			WB_LOAD: wb_data = load_data;
			WB_LINK: wb_data = pc_plus4; // JAL link
			default: wb_data = alu_result;
		endcase
	end

endmodule

//--- source/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
	input  logic          clk,
	input  logic          reset,
	input  logic          is_branch,
	input  logic          br_taken,
	input  logic          is_jal,
	input  rv_pkg::word_t imm,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t pc_plus4
);
	import rv_pkg::*;

	word_t pc_target; // PC-relative jump or branch target
	word_t pc_next;
	logic  redirect;

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + imm;
	assign redirect  = is_jal | (is_branch & br_taken);
	assign pc_next   = redirect ? pc_target : pc_plus4;

	// Start at address zero
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

//--- source/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
	input  rv_pkg::word_t   addr,
	input  rv_pkg::word_t   store_data,
	input  rv_pkg::funct3_t funct3,
	input  logic            mem_wr,
	output rv_pkg::word_t   dmem_addr,
	output rv_pkg::word_t   dmem_wdata,
	output rv_pkg::strb_t   dmem_strb,
	output logic            dmem_we,
	input  rv_pkg::word_t   dmem_rdata,
	output rv_pkg::word_t   load_data
);
	import rv_pkg::*;

	strb_t      lanes;    // Strobe before the write gate
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;

	assign dmem_addr = addr; // Memory picks the word, lanes handled here

	// Store side, data copied into every lane
	always_comb begin
		case (funct3[1:0])
			2'b00: begin // SB
				dmem_wdata = {4{store_data[7:0]}};
				lanes      = strb_t'(4'b0001 << addr[1:0]);
			end
			2'b01: begin // SH, aligned half
				dmem_wdata = {2{store_data[15:0]}};
				lanes      = addr[1] ? 4'b1100 : 4'b0011;
			end
			2'b10: begin // SW
				dmem_wdata = store_data;
				lanes      = 4'b1111;
			end
			default: begin
				dmem_wdata = store_data;
				lanes      = '0;
			end
		endcase
	end

	assign dmem_strb = mem_wr ? lanes : '0;
	assign dmem_we   = mem_wr & (|lanes); // Bad store width writes nothing

	// Load side lane pick
	assign ld_byte = dmem_rdata[8*addr[1:0] +: 8];
	assign ld_half = addr[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

	always_comb begin
		case (funct3)
			3'b000:  load_data = {{24{ld_byte[7]}}, ld_byte};  // LB
			3'b001:  load_data = {{16{ld_half[15]}}, ld_half}; // LH
			3'b100:  load_data = {24'b0, ld_byte};             // LBU
			3'b101:  load_data = {16'b0, ld_half};             // LHU
			default: load_data = dmem_rdata;                   // LW
		endcase
	end

endmodule

//--- source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	input  rv_pkg::alu_op_t alu_op,
	input  rv_pkg::funct3_t funct3,
	output rv_pkg::word_t   result,
	output logic            br_taken
);
	import rv_pkg::*;

	logic [4:0] shamt; // Low five bits only
	logic       lt_s;
	logic       lt_u;

	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (alu_op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = word_t'($signed(a) >>> shamt); // Sign fill
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0;
		endcase
	end

	// Branch condition; used only when the decoder flags a branch
	always_comb begin
		case (funct3)
			3'b000:  br_taken = (a == b); // BEQ
			3'b001:  br_taken = (a != b); // BNE
			3'b100:  br_taken = lt_s;     // BLT
			3'b101:  br_taken = ~lt_s;    // BGE
			3'b110:  br_taken = lt_u;     // BLTU
			3'b111:  br_taken = ~lt_u;    // BGEU
			default: br_taken = 1'b0;
		endcase
	end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input  logic              clk,
	input  logic              reset,
	input  logic              we,
	input  rv_pkg::reg_addr_t rs1,
	input  rv_pkg::reg_addr_t rs2,
	input  rv_pkg::reg_addr_t rd,
	input  rv_pkg::word_t     wdata,
	output rv_pkg::word_t     rs1_data,
	output rv_pkg::word_t     rs2_data
);
	import rv_pkg::*;

	// x1..x31 only, x0 has no storage
	word_t regs [1:NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rd] <= wdata; // rd never zero when we is set
		end
	end

	// Async reads, old value during a same-cycle write
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
	input  rv_pkg::word_t     instr,
	output rv_pkg::reg_addr_t rs1,
	output rv_pkg::reg_addr_t rs2,
	output rv_pkg::reg_addr_t rd,
	output rv_pkg::word_t     imm,
	output rv_pkg::alu_op_t   alu_op,
	output rv_pkg::funct3_t   funct3,
	output logic              sel_b,
	output logic              reg_wr,
	output logic              mem_rd,
	output logic              mem_wr,
	output logic              is_branch,
	output logic              is_jal,
	output rv_pkg::wb_sel_t   wb_sel
);
	import rv_pkg::*;

	opcode_t opcode;
	logic    alt;    // funct7 selects SUB / SRA
	logic    wr_req; // Register write before the x0 check

	// funct3 to ALU code; SUB only exists in R type
	function automatic alu_op_t alu_from_funct(funct3_t f3, logic alt_sub, logic alt_sra);
		alu_op_t op;
		case (f3)
			3'b000:  op = alt_sub ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt_sra ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	// Fixed field positions
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign alt    = (instr[31:25] == FUNCT7_ALT);

	always_comb begin
		// Unknown opcodes fall through as a no-op
		alu_op    = ALU_ADD;
		sel_b     = 1'b0;
		wr_req    = 1'b0;
		mem_rd    = 1'b0;
		mem_wr    = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		wb_sel    = WB_ALU;
		imm       = {{20{instr[31]}}, instr[31:20]}; // I format
		case (opcode)
			OPC_R: begin
				wr_req = 1'b1;
				alu_op = alu_from_funct(funct3, alt, alt);
			end
			OPC_I: begin
				wr_req = 1'b1;
				sel_b  = 1'b1;
				alu_op = alu_from_funct(funct3, 1'b0, alt); // Upper imm bits flag SRAI
			end
			OPC_LOAD: begin
				wr_req = 1'b1;
				sel_b  = 1'b1; // rs1 + offset
				mem_rd = 1'b1;
				wb_sel = WB_LOAD;
			end
			OPC_STORE: begin
				sel_b  = 1'b1;
				mem_wr = 1'b1;
				imm    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			OPC_BRANCH: begin
				is_branch = 1'b1; // Compare rs1 with rs2
				alu_op    = ALU_SUB;
				imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			OPC_JAL: begin
				wr_req = 1'b1;
				is_jal = 1'b1;
				wb_sel = WB_LINK;
				imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default: ;
		endcase
	end

	// x0 writes dropped here once for the whole core
	assign reg_wr = wr_req & (rd != '0);

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

	// Machine widths
	localparam int XLEN     = 32;
	localparam int NUM_REGS = 32; // x0 included

	// Types with a fixed meaning
	typedef logic [XLEN-1:0] word_t; // Data, address or instruction
	typedef logic [4:0]      reg_addr_t;
	typedef logic [6:0]      opcode_t;
	typedef logic [2:0]      funct3_t;
	typedef logic [3:0]      alu_op_t;
	typedef logic [1:0]      wb_sel_t;
	typedef logic [3:0]      strb_t; // One bit per byte lane

	// Major opcodes of the supported subset
	localparam opcode_t OPC_R      = 7'b0110011;
	localparam opcode_t OPC_I      = 7'b0010011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;

	// funct7 for SUB and SRA / SRAI
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

	// ALU operation codes
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SLL  = 4'd1;
	localparam alu_op_t ALU_SLT  = 4'd2;
	localparam alu_op_t ALU_SLTU = 4'd3;
	localparam alu_op_t ALU_XOR  = 4'd4;
	localparam alu_op_t ALU_SRL  = 4'd5;
	localparam alu_op_t ALU_SRA  = 4'd6;
	localparam alu_op_t ALU_OR   = 4'd7;
	localparam alu_op_t ALU_AND  = 4'd8;
	localparam alu_op_t ALU_SUB  = 4'd9;

	// Write-back sources
	localparam wb_sel_t WB_ALU  = 2'd0;
	localparam wb_sel_t WB_LOAD = 2'd1;
	localparam wb_sel_t WB_LINK = 2'd2; // PC plus four for JAL

endpackage
